/* rtl/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // widths fixed by rv32 and the axi port
    localparam int xlen       = 32;
    localparam int strb_width = xlen / 8;  // byte lanes per word
    localparam int id_width   = 4;

    localparam logic [1:0] axi_resp_okay  = 2'b00;
    localparam logic [1:0] axi_burst_incr = 2'b01;

    // access size, same code as axi axsize
    typedef enum logic [2:0] {
        size_byte = 3'b000,
        size_half = 3'b001,
        size_word = 3'b010
    } lsu_size_e;

    // request from execute stage
    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;   // store data, low bits for sb/sh
        lsu_size_e       size;
        logic            is_write;
        logic            is_unsigned;  // lbu / lhu
    } lsu_req_t;

    // response back to the core
    typedef struct packed {
        logic [xlen-1:0] rdata;
        logic            error;
    } lsu_rsp_t;

    // aw and ar share one layout
    typedef struct packed {
        logic [id_width-1:0] id;
        logic [xlen-1:0]     addr;
        logic [7:0]          len;    // beats minus one
        lsu_size_e           size;
        logic [1:0]          burst;
    } axi_ax_t;

    typedef struct packed {
        logic [xlen-1:0]       data;
        logic [strb_width-1:0] strb;
        logic                  last;
    } axi_w_t;

    typedef struct packed {
        logic [id_width-1:0] id;
        logic [1:0]          resp;
    } axi_b_t;

    typedef struct packed {
        logic [id_width-1:0] id;
        logic [xlen-1:0]     data;
        logic [1:0]          resp;
    } axi_r_t;

endpackage

`default_nettype wire

/* rtl/lsu_store_align.sv */
`default_nettype none

module lsu_store_align import lsu_pkg::*; (
    input  lsu_req_t saved_req,
    output axi_w_t   w
);

    logic [1:0]            offset;   // byte lane of the access
    logic [xlen-1:0]       lane_data;
    logic [strb_width-1:0] lane_strb;

    assign offset = saved_req.addr[1:0];

    // data is copied to every lane, the strobe picks the live bytes
    always_comb begin
        lane_data = saved_req.wdata;
        lane_strb = '0;
        case (saved_req.size)
            size_byte: begin
                lane_data = {4{saved_req.wdata[7:0]}};
                lane_strb = strb_width'(4'b0001 << offset);  // sb
            end
            size_half: begin
                lane_data = {2{saved_req.wdata[15:0]}};
                lane_strb = strb_width'(4'b0011 << {offset[1], 1'b0});  // sh
            end
            size_word: begin
                lane_strb = '1;  // sw, all lanes
            end
            default: begin
                lane_strb = '0;  // never issued by ctrl
            end
        endcase
    end

    assign w.data = lane_data;
    assign w.strb = lane_strb;
    assign w.last = 1'b1;  // single beat

endmodule

`default_nettype wire

/* rtl/lsu_load_align.sv */
`default_nettype none

module lsu_load_align import lsu_pkg::*; (
    input  lsu_req_t        saved_req,
    input  logic [xlen-1:0] rdata,
    output logic [xlen-1:0] load_data
);

    logic [xlen-1:0] shifted;  // addressed part moved to bit 0
    logic            fill;     // upper bit value

    // byte offset times 8
    assign shifted = rdata >> {saved_req.addr[1:0], 3'b000};

    always_comb begin
        fill      = 1'b0;
        load_data = '0;
        case (saved_req.size)
            size_byte: begin
                fill      = shifted[7] & ~saved_req.is_unsigned;  // lb vs lbu
                load_data = {{(xlen-8){fill}}, shifted[7:0]};
            end
            size_half: begin
                // aligned half sits at offset 0 or 2
                fill      = shifted[15] & ~saved_req.is_unsigned;
                load_data = {{(xlen-16){fill}}, shifted[15:0]};
            end
            size_word: begin
                load_data = rdata;  // lw passes through
            end
            default: begin
                load_data = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/lsu_ctrl.sv */
`default_nettype none

module lsu_ctrl import lsu_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    // core side
    input  logic            req_valid,
    input  lsu_req_t        req,
    output logic            req_ready,
    output logic            rsp_valid,
    output lsu_rsp_t        rsp,
    // axi master
    output logic            aw_valid,
    input  logic            aw_ready,
    output axi_ax_t         aw,
    output logic            w_valid,
    input  logic            w_ready,
    input  logic            b_valid,
    output logic            b_ready,
    input  axi_b_t          b,
    output logic            ar_valid,
    input  logic            ar_ready,
    output axi_ax_t         ar,
    input  logic            r_valid,
    output logic            r_ready,
    input  axi_r_t          r,
    // to the aligners
    output lsu_req_t        saved_req,
    input  logic [xlen-1:0] load_data
);

    typedef enum logic [2:0] {
        st_idle,
        st_wr_addr,
        st_wr_data,
        st_wr_resp,
        st_rd_addr,
        st_rd_data,
        st_err_rsp   // misaligned or bad size never reaches the bus
    } state_e;

    state_e              state;
    state_e              next_state;
    logic [id_width-1:0] cur_id;
    logic                accept;
    logic                req_bad;
    axi_ax_t             ax;

    // halfword needs bit 0 clear and word needs both low bits clear
    function automatic logic is_misaligned(input lsu_req_t rq);
        logic bad;
        case (rq.size)
            size_byte: bad = 1'b0;
            size_half: bad = rq.addr[0];
            size_word: bad = |rq.addr[1:0];
            default:   bad = 1'b1;  // unknown size
        endcase
        return bad;
    endfunction

    assign req_ready = (state == st_idle);
    assign accept    = req_valid & req_ready;
    assign req_bad   = is_misaligned(req);

    // single beat so aw and ar carry the same fields
    assign ax.id    = cur_id;
    assign ax.addr  = saved_req.addr;
    assign ax.len   = 8'd0;
    assign ax.size  = saved_req.size;
    assign ax.burst = axi_burst_incr;
    assign aw       = ax;
    assign ar       = ax;

    always_ff @(posedge clock) begin
        if (reset) begin
            state  <= st_idle;
            cur_id <= '0;
        end else begin
            state <= next_state;
            if (accept) begin
                cur_id <= cur_id + 1'b1;  // wraps mod 16
            end
        end
    end

    // request payload captured on accept
    always_ff @(posedge clock) begin
        if (accept) begin
            saved_req <= req;
        end
    end

    always_comb begin
        next_state = state;
        aw_valid   = 1'b0;
        w_valid    = 1'b0;
        b_ready    = 1'b0;
        ar_valid   = 1'b0;
        r_ready    = 1'b0;
        rsp_valid  = 1'b0;
        rsp        = '0;

        case (state)
            st_idle: begin
                if (accept) begin
                    if (req_bad) begin
                        next_state = st_err_rsp;
                    end else if (req.is_write) begin
                        next_state = st_wr_addr;
                    end else begin
                        next_state = st_rd_addr;
                    end
                end
            end
            st_wr_addr: begin
                aw_valid = 1'b1;  // held until slave takes it
                if (aw_ready) begin
                    next_state = st_wr_data;
                end
            end
            st_wr_data: begin
                w_valid = 1'b1;
                if (w_ready) begin
                    next_state = st_wr_resp;
                end
            end
            st_wr_resp: begin
                b_ready = 1'b1;
                if (b_valid) begin
                    rsp_valid  = 1'b1;
                    rsp.error  = (b.resp != axi_resp_okay) | (b.id != cur_id);
                    next_state = st_idle;
                end
            end
            st_rd_addr: begin
                ar_valid = 1'b1;
                if (ar_ready) begin
                    next_state = st_rd_data;
                end
            end
            st_rd_data: begin
                r_ready = 1'b1;
                if (r_valid) begin
                    rsp_valid  = 1'b1;
                    rsp.error  = (r.resp != axi_resp_okay) | (r.id != cur_id);
                    rsp.rdata  = rsp.error ? '0 : load_data;  // aligned data from r
                    next_state = st_idle;
                end
            end
            st_err_rsp: begin
                rsp_valid  = 1'b1;
                rsp.error  = 1'b1;
                next_state = st_idle;
            end
            default: next_state = st_idle;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/lsu_top.sv */
`default_nettype none

module lsu_top import lsu_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    // execute stage
    input  logic     req_valid,
    input  lsu_req_t req,
    output logic     req_ready,
    output logic     rsp_valid,
    output lsu_rsp_t rsp,
    // write address
    output logic     aw_valid,
    input  logic     aw_ready,
    output axi_ax_t  aw,
    // write data
    output logic     w_valid,
    input  logic     w_ready,
    output axi_w_t   w,
    // write response
    input  logic     b_valid,
    output logic     b_ready,
    input  axi_b_t   b,
    // read address
    output logic     ar_valid,
    input  logic     ar_ready,
    output axi_ax_t  ar,
    // read data
    input  logic     r_valid,
    output logic     r_ready,
    input  axi_r_t   r
);

    lsu_req_t        saved_req;  // captured request, feeds both aligners
    logic [xlen-1:0] load_data;

    lsu_ctrl u_lsu_ctrl (
        .clock     (clock),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .aw        (aw),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .b         (b),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .ar        (ar),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .r         (r),
        .saved_req (saved_req),
        .load_data (load_data)
    );

    lsu_store_align u_lsu_store_align (
        .saved_req (saved_req),
        .w         (w)
    );

    // combinational from r data, same cycle as the r handshake
    lsu_load_align u_lsu_load_align (
        .saved_req (saved_req),
        .rdata     (r.data),
        .load_data (load_data)
    );

endmodule

`default_nettype wire

/* test/axi_mem_model.sv */
`default_nettype none

module axi_mem_model import lsu_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    inject_err,  // answer the current b or r with slverr
    input  logic    aw_valid,
    output logic    aw_ready,
    input  axi_ax_t aw,
    input  logic    w_valid,
    output logic    w_ready,
    input  axi_w_t  w,
    output logic    b_valid,
    input  logic    b_ready,
    output axi_b_t  b,
    input  logic    ar_valid,
    output logic    ar_ready,
    input  axi_ax_t ar,
    output logic    r_valid,
    input  logic    r_ready,
    output axi_r_t  r
);

    localparam logic [1:0] resp_slverr = 2'b10;

    logic [xlen-1:0] mem [64];  // word memory, index is addr[7:2]

    // outputs move a short delay after the edge
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clock);
            #5;
        end
    endtask

    task automatic serve_write;
        axi_ax_t a;
        axi_w_t  d;
        int      k;
        idle_cycles($urandom_range(3));
        a        = aw;
        aw_ready = 1'b1;
        idle_cycles(1);  // handshake on this edge
        aw_ready = 1'b0;
        while (!w_valid) idle_cycles(1);
        idle_cycles($urandom_range(3));
        d       = w;
        w_ready = 1'b1;
        idle_cycles(1);
        w_ready = 1'b0;
        if (!inject_err) begin
            for (k = 0; k < strb_width; k++) begin
                if (d.strb[k]) mem[a.addr[7:2]][8*k +: 8] = d.data[8*k +: 8];
            end
        end
        idle_cycles($urandom_range(3));
        b       = '{id: a.id, resp: inject_err ? resp_slverr : axi_resp_okay};
        b_valid = 1'b1;
        while (!b_ready) idle_cycles(1);
        idle_cycles(1);
        b_valid = 1'b0;
    endtask

    task automatic serve_read;
        axi_ax_t a;
        idle_cycles($urandom_range(3));
        a        = ar;
        ar_ready = 1'b1;
        idle_cycles(1);
        ar_ready = 1'b0;
        idle_cycles($urandom_range(3));
        // junk data on error, the unit must zero it
        r.id    = a.id;
        r.data  = inject_err ? 32'hdead_beef : mem[a.addr[7:2]];
        r.resp  = inject_err ? resp_slverr : axi_resp_okay;
        r_valid = 1'b1;
        while (!r_ready) idle_cycles(1);
        idle_cycles(1);
        r_valid = 1'b0;
    endtask

    initial begin
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b_valid  = 1'b0;
        b        = '0;
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r        = '0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'h9e37_79b9 * (i + 1);  // mixed sign bits per word
        end
        forever begin
            @(posedge clock);
            #5;
            if (!reset && aw_valid) serve_write;
            else if (!reset && ar_valid) serve_read;
        end
    end

endmodule

`default_nettype wire

/* test/lsu_tb.sv */
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

    localparam int num_ops        = 300;
    localparam int cycles_per_op  = 20;
    localparam int timeout_cycles = num_ops * cycles_per_op;
    localparam int seed           = 67512;

    logic     clock;
    logic     reset;
    logic     req_valid;
    lsu_req_t req;
    logic     req_ready;
    logic     rsp_valid;
    lsu_rsp_t rsp;
    logic     aw_valid;
    logic     aw_ready;
    logic     w_valid;
    logic     w_ready;
    logic     b_valid;
    logic     b_ready;
    logic     ar_valid;
    logic     ar_ready;
    logic     r_valid;
    logic     r_ready;
    axi_ax_t  aw;
    axi_ax_t  ar;
    axi_w_t   w;
    axi_b_t   b;
    axi_r_t   r;
    logic     inject_err;

    // expectations for the request in flight
    lsu_req_t              cur_req;
    logic [id_width-1:0]   tag;  // accepted count incl. this one
    logic [strb_width-1:0] exp_strb;
    logic [xlen-1:0]       exp_rdata;
    logic                  exp_error;
    logic                  misaligned;
    logic                  started = 1'b0;
    axi_ax_t               exp_ax;
    logic [xlen-1:0]       ref_mem [64];
    int                    cycles = 0;

    lsu_top u_lsu_top (.*);
    axi_mem_model u_axi_mem_model (.*);

    assign exp_ax = '{id: tag, addr: cur_req.addr, len: 8'd0, size: cur_req.size,
                      burst: axi_burst_incr};

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    // byte lanes touched by an access
    function automatic logic [strb_width-1:0] lane_mask(input lsu_size_e sz,
                                                        input logic [1:0] off);
        case (sz)
            size_byte: return 4'b0001 << off;
            size_half: return 4'b0011 << off;
            default:   return 4'b1111;
        endcase
    endfunction

    function automatic logic bad_request(input lsu_req_t rq);
        if (rq.size == size_byte) return 1'b0;
        if (rq.size == size_half) return rq.addr[0];
        if (rq.size == size_word) return rq.addr[1:0] != 2'b00;
        return 1'b1;  // unknown size
    endfunction

    function automatic logic [xlen-1:0] extend_load(input lsu_req_t rq,
                                                    input logic [xlen-1:0] word);
        logic [7:0]  bt;
        logic [15:0] hw;
        bt = word[8*rq.addr[1:0] +: 8];
        hw = word[8*rq.addr[1:0] +: 16];
        if (rq.size == size_byte) return rq.is_unsigned ? xlen'(bt) : xlen'($signed(bt));
        if (rq.size == size_half) return rq.is_unsigned ? xlen'(hw) : xlen'($signed(hw));
        return word;
    endfunction

    task automatic run_op;
        lsu_req_t rq;
        int       k;
        int       off;
        rq.addr = {24'h0, 6'($urandom_range(63)), 2'($urandom_range(3))};
        case ($urandom_range(9))
            0:       rq.size = lsu_size_e'(3'b011);  // not a legal size
            1, 2, 3: rq.size = size_byte;
            4, 5, 6: rq.size = size_half;
            default: rq.size = size_word;
        endcase
        if ($urandom_range(2) != 0) begin  // mostly aligned
            if (rq.size == size_half) rq.addr[0] = 1'b0;
            if (rq.size == size_word) rq.addr[1:0] = 2'b00;
        end
        rq.wdata       = $urandom;
        rq.is_write    = 1'($urandom_range(1));
        rq.is_unsigned = 1'($urandom_range(1));
        off            = rq.addr[1:0];
        cur_req        = rq;
        tag            = tag + 1'b1;
        misaligned     = bad_request(rq);
        inject_err     = !misaligned && ($urandom_range(9) == 0);
        exp_error      = misaligned | inject_err;
        exp_strb       = lane_mask(rq.size, rq.addr[1:0]);
        exp_rdata      = (exp_error || rq.is_write) ? '0 : extend_load(rq, ref_mem[rq.addr[7:2]]);
        req            = rq;
        req_valid      = 1'b1;
        while (!req_ready) @(negedge clock);  // wait for the idle state
        @(posedge clock);  // taken on this edge
        #10;
        req_valid = 1'b0;
        do @(negedge clock); while (!rsp_valid);
        if (rq.is_write && !exp_error) begin
            for (k = 0; k < strb_width; k++) begin
                if (exp_strb[k]) ref_mem[rq.addr[7:2]][8*k +: 8] = rq.wdata[8*(k-off) +: 8];
            end
        end
        @(posedge clock);
        #10;
    endtask

    initial begin
        void'($urandom(seed));
        reset      = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        inject_err = 1'b0;
        cur_req    = '0;
        tag        = '0;
        exp_strb   = '0;
        exp_rdata  = '0;
        exp_error  = 1'b0;
        misaligned = 1'b0;
        repeat (2) @(posedge clock);
        #10;
        reset = 1'b0;
        for (int i = 0; i < 64; i++) ref_mem[i] = u_axi_mem_model.mem[i];
        @(posedge clock);
        #10;
        for (int n = 0; n < num_ops; n++) run_op();
        $display("Verification passed");
        $finish;
    end

    always @(posedge clock) begin
        if (reset) started <= 1'b0;
        else if (req_valid && req_ready) started <= 1'b1;
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) stop_run("run timed out before all operations finished");
    end

    assert property (@(posedge clock) disable iff (reset) !started |-> req_ready && !rsp_valid
        && !aw_valid && !w_valid && !b_ready && !ar_valid && !r_ready)
        else stop_run("outputs left the reset state before the first request");
    assert property (@(posedge clock) disable iff (reset) aw_valid && aw_ready |-> aw == exp_ax)
        else stop_run($sformatf("ERR aw exp %h got %h", $sampled(exp_ax), $sampled(aw)));
    assert property (@(posedge clock) disable iff (reset) ar_valid && ar_ready |-> ar == exp_ax)
        else stop_run($sformatf("ERR ar exp %h got %h", $sampled(exp_ax), $sampled(ar)));
    assert property (@(posedge clock) disable iff (reset) w_valid && w_ready |-> w.strb == exp_strb)
        else stop_run($sformatf("ERR w.strb exp %h got %h", $sampled(exp_strb), $sampled(w.strb)));
    assert property (@(posedge clock) disable iff (reset) w_valid && w_ready |-> w.last)
        else stop_run($sformatf("ERR w.last exp 1 got %h", $sampled(w.last)));
    // valid held with a stable payload
    assert property (@(posedge clock) disable iff (reset)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else stop_run("aw_valid dropped or aw changed before aw_ready");
    assert property (@(posedge clock) disable iff (reset)
        w_valid && !w_ready |=> w_valid && $stable(w))
        else stop_run("w_valid dropped or w changed before w_ready");
    assert property (@(posedge clock) disable iff (reset)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
        else stop_run("ar_valid dropped or ar changed before ar_ready");
    assert property (@(posedge clock) disable iff (reset) rsp_valid |-> rsp.error == exp_error)
        else stop_run($sformatf("ERR rsp.error exp %h got %h", $sampled(exp_error),
                      $sampled(rsp.error)));
    assert property (@(posedge clock) disable iff (reset) rsp_valid |-> rsp.rdata == exp_rdata)
        else stop_run($sformatf("ERR rsp.rdata exp %h got %h", $sampled(exp_rdata),
                      $sampled(rsp.rdata)));
    assert property (@(posedge clock) disable iff (reset)
        req_valid && req_ready && misaligned |=> rsp_valid)
        else stop_run("misaligned request not answered in the cycle after acceptance");
    assert property (@(posedge clock) disable iff (reset)
        !req_ready && misaligned |-> !aw_valid && !ar_valid)
        else stop_run("misaligned request reached the bus");

endmodule

`default_nettype wire

/* lsu.f */
rtl/lsu_pkg.sv
rtl/lsu_store_align.sv
rtl/lsu_load_align.sv
rtl/lsu_ctrl.sv
rtl/lsu_top.sv
test/axi_mem_model.sv
test/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - rtl/lsu_pkg.sv
  - rtl/lsu_store_align.sv
  - rtl/lsu_load_align.sv
  - rtl/lsu_ctrl.sv
  - rtl/lsu_top.sv
  - target: test
    files:
      - test/axi_mem_model.sv
      - test/lsu_tb.sv
